//--- decode_tb.sv
`timescale 1ns/10ps

module decode_tb;

	localparam logic [3:0] br_none = {1'b0, rv_pkg::dont_branch};
	localparam logic [3:0] br_jal  = {1'b0, rv_pkg::unc_branch};
	localparam logic [3:0] br_jalr = {1'b1, rv_pkg::unc_branch};

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic        in_ready;
	logic [31:0] in_pc;
	logic [31:0] in_inst;
	logic        out_valid;
	logic        out_ready;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [31:0] pc;
	logic [31:0] imm;
	logic [9:0]  mux_sel;
	logic [3:0]  br_ctrl;
	logic [4:0]  alu_func;
	logic [3:0]  mem_cmd;
	logic [4:0]  rd;

	// Stimulus table, one row per fetched instruction.
	logic [31:0] tbl_pc[64];
	logic [31:0] tbl_inst[64];
	logic        tbl_legal[64];
	logic [31:0] exp_imm[64];
	logic [4:0]  exp_rd[64];
	logic [4:0]  exp_rs1[64];
	logic [4:0]  exp_rs2[64];
	logic [4:0]  exp_alu[64];
	logic [3:0]  exp_mem[64];
	logic [3:0]  exp_br[64];
	logic [9:0]  exp_mux[64];
	int          n_entries;
	int          sb[$];
	logic [4:0]  hist_ex;
	logic [4:0]  hist_mem;
	logic [31:0] rng;

	logic        held;
	logic [31:0] held_pc;
	logic [31:0] held_imm;
	logic [37:0] held_ctrl;
	wire  [37:0] ctrl_bus = {rs1, rs2, mux_sel, br_ctrl, alu_func, mem_cmd, rd};

	decode_top #(.XLEN(32)) DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_pc     (in_pc),
		.in_inst   (in_inst),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.rs1       (rs1),
		.rs2       (rs2),
		.pc        (pc),
		.imm       (imm),
		.mux_sel   (mux_sel),
		.br_ctrl   (br_ctrl),
		.alu_func  (alu_func),
		.mem_cmd   (mem_cmd),
		.rd        (rd)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped after an error.");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp)
			fail_run($sformatf("FAILED at time %0t: %s = %h, expected %h",
				$time, name, got, exp));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Nearest older producer wins, and x0 always reads the register file.
	function automatic logic [2:0] expected_fwd(input logic [4:0] src);
		if (src == 5'd0)
			return rv_pkg::f0;
		else if (src == hist_ex)
			return rv_pkg::f1;
		else if (src == hist_mem)
			return rv_pkg::f2;
		else
			return rv_pkg::f0;
	endfunction

	task automatic entry(input logic [31:0] inst, input logic [31:0] imm_v,
			input logic [4:0] rd_v, input logic [4:0] alu, input logic [3:0] mem,
			input logic [3:0] br, input logic [1:0] opa, input logic [1:0] opb);
		tbl_inst[n_entries]  = inst;
		tbl_pc[n_entries]    = 32'h0000_1000 + 32'(n_entries * 4);
		tbl_legal[n_entries] = 1'b1;
		exp_imm[n_entries]   = imm_v;
		exp_rd[n_entries]    = rd_v;
		exp_rs1[n_entries]   = inst[19:15];
		exp_rs2[n_entries]   = inst[24:20];
		exp_alu[n_entries]   = alu;
		exp_mem[n_entries]   = mem;
		exp_br[n_entries]    = br;
		exp_mux[n_entries]   = {opa, opb, expected_fwd(inst[19:15]), expected_fwd(inst[24:20])};
		hist_mem = hist_ex;
		hist_ex  = rd_v;
		n_entries++;
	endtask

	task automatic bad(input logic [31:0] inst);
		tbl_inst[n_entries]  = inst;
		tbl_pc[n_entries]    = 32'h0000_1000 + 32'(n_entries * 4);
		tbl_legal[n_entries] = 1'b0;
		n_entries++;
	endtask

	task automatic r_entry(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] s2,
			input logic [4:0] s1, input logic [4:0] d, input logic [4:0] alu);
		entry({f7, s2, s1, f3, d, rv_pkg::r_type}, 32'h0, d, alu, rv_pkg::mem_none, br_none,
			rv_pkg::sel_rs, rv_pkg::sel_rs);
	endtask

	task automatic ia_entry(input logic [11:0] imm12, input logic [4:0] s1,
			input logic [2:0] f3, input logic [4:0] d, input logic [4:0] alu,
			input logic [31:0] imm_v);
		entry({imm12, s1, f3, d, rv_pkg::i_arith_type}, imm_v, d, alu, rv_pkg::mem_none,
			br_none, rv_pkg::sel_rs, rv_pkg::sel_imm);
	endtask

	task automatic build_table();
		hist_ex   = 5'd0;
		hist_mem  = 5'd0;
		n_entries = 0;
		// R-type: funct7, funct3, rs2, rs1, rd, ALU function.
		r_entry(7'h00, 3'b000, 5'd2, 5'd1, 5'd3, rv_pkg::alu_add);
		r_entry(7'h20, 3'b000, 5'd3, 5'd1, 5'd4, rv_pkg::alu_sub);
		r_entry(7'h00, 3'b100, 5'd3, 5'd4, 5'd5, rv_pkg::alu_xor);
		r_entry(7'h00, 3'b110, 5'd0, 5'd5, 5'd6, rv_pkg::alu_or);
		r_entry(7'h00, 3'b111, 5'd6, 5'd6, 5'd6, rv_pkg::alu_and);
		r_entry(7'h00, 3'b001, 5'd6, 5'd0, 5'd7, rv_pkg::alu_sll);
		r_entry(7'h00, 3'b101, 5'd6, 5'd7, 5'd8, rv_pkg::alu_srl);
		r_entry(7'h20, 3'b101, 5'd8, 5'd7, 5'd9, rv_pkg::alu_sra);
		r_entry(7'h00, 3'b010, 5'd9, 5'd8, 5'd10, rv_pkg::alu_slt);
		r_entry(7'h00, 3'b011, 5'd1, 5'd10, 5'd11, rv_pkg::alu_sltu);
		r_entry(7'h01, 3'b000, 5'd11, 5'd10, 5'd12, rv_pkg::alu_mul);
		r_entry(7'h01, 3'b001, 5'd12, 5'd11, 5'd13, rv_pkg::alu_mulh);
		r_entry(7'h01, 3'b010, 5'd13, 5'd2, 5'd14, rv_pkg::alu_mulhsu);
		r_entry(7'h01, 3'b011, 5'd14, 5'd13, 5'd15, rv_pkg::alu_mulhu);
		r_entry(7'h00, 3'b000, 5'd2, 5'd1, 5'd0, rv_pkg::alu_add);
		r_entry(7'h01, 3'b000, 5'd0, 5'd0, 5'd9, rv_pkg::alu_mul);
		bad({7'h20, 5'd1, 5'd2, 3'b001, 5'd3, rv_pkg::r_type});
		bad({7'h01, 5'd1, 5'd2, 3'b100, 5'd3, rv_pkg::r_type});
		// I-arith: imm12, rs1, funct3, rd, ALU function, sign-extended immediate.
		ia_entry(12'hfff, 5'd1, 3'b000, 5'd3, rv_pkg::alu_add, 32'hffff_ffff);
		ia_entry(12'h7ff, 5'd3, 3'b100, 5'd4, rv_pkg::alu_xor, 32'h0000_07ff);
		ia_entry(12'h800, 5'd4, 3'b110, 5'd5, rv_pkg::alu_or, 32'hffff_f800);
		ia_entry(12'h0ff, 5'd5, 3'b111, 5'd6, rv_pkg::alu_and, 32'h0000_00ff);
		ia_entry(12'hffe, 5'd0, 3'b010, 5'd7, rv_pkg::alu_slt, 32'hffff_fffe);
		ia_entry(12'h001, 5'd7, 3'b011, 5'd8, rv_pkg::alu_sltu, 32'h0000_0001);
		ia_entry(12'h003, 5'd8, 3'b001, 5'd9, rv_pkg::alu_sll, 32'h0000_0003);
		ia_entry(12'h004, 5'd9, 3'b101, 5'd10, rv_pkg::alu_srl, 32'h0000_0004);
		ia_entry(12'h404, 5'd10, 3'b101, 5'd11, rv_pkg::alu_sra, 32'h0000_0404);
		bad({12'h403, 5'd1, 3'b001, 5'd12, rv_pkg::i_arith_type});
		bad({12'h024, 5'd1, 3'b101, 5'd12, rv_pkg::i_arith_type});
		// The dropped writes to x12 must not show up in the history.
		r_entry(7'h00, 3'b000, 5'd11, 5'd12, 5'd13, rv_pkg::alu_add);
		entry({12'h010, 5'd2, 3'b010, 5'd9, rv_pkg::i_ld_type}, 32'h10, 5'd9, rv_pkg::alu_add,
			4'b0010, br_none, rv_pkg::sel_rs, rv_pkg::sel_imm);
		entry({12'hfff, 5'd9, 3'b100, 5'd10, rv_pkg::i_ld_type}, 32'hffff_ffff, 5'd10,
			rv_pkg::alu_add, 4'b0100, br_none, rv_pkg::sel_rs, rv_pkg::sel_imm);
		entry({7'h00, 5'd9, 5'd10, 3'b000, 5'd5, rv_pkg::s_type}, 32'h5, 5'd0, rv_pkg::alu_add,
			4'b1000, br_none, rv_pkg::sel_rs, rv_pkg::sel_imm);
		entry({7'h7f, 5'd5, 5'd2, 3'b010, 5'd24, rv_pkg::s_type}, 32'hffff_fff8, 5'd0,
			rv_pkg::alu_add, 4'b1010, br_none, rv_pkg::sel_rs, rv_pkg::sel_imm);
		entry({7'h00, 5'd2, 5'd1, 3'b000, 5'd16, rv_pkg::b_type}, 32'h10, 5'd0, rv_pkg::alu_xor,
			rv_pkg::mem_none, 4'b0000, rv_pkg::sel_rs, rv_pkg::sel_rs);
		entry({7'h00, 5'd4, 5'd3, 3'b001, 5'd16, rv_pkg::b_type}, 32'h10, 5'd0, rv_pkg::alu_xor,
			rv_pkg::mem_none, 4'b0001, rv_pkg::sel_rs, rv_pkg::sel_rs);
		entry({7'h7f, 5'd4, 5'd3, 3'b100, 5'd29, rv_pkg::b_type}, 32'hffff_fffc, 5'd0,
			rv_pkg::alu_slt, rv_pkg::mem_none, 4'b0100, rv_pkg::sel_rs, rv_pkg::sel_rs);
		entry({7'h00, 5'd6, 5'd5, 3'b101, 5'd8, rv_pkg::b_type}, 32'h8, 5'd0, rv_pkg::alu_slt,
			rv_pkg::mem_none, 4'b0101, rv_pkg::sel_rs, rv_pkg::sel_rs);
		entry({7'h00, 5'd6, 5'd5, 3'b110, 5'd8, rv_pkg::b_type}, 32'h8, 5'd0, rv_pkg::alu_sltu,
			rv_pkg::mem_none, 4'b0110, rv_pkg::sel_rs, rv_pkg::sel_rs);
		entry({7'h00, 5'd2, 5'd1, 3'b111, 5'd16, rv_pkg::b_type}, 32'h10, 5'd0, rv_pkg::alu_sltu,
			rv_pkg::mem_none, 4'b0111, rv_pkg::sel_rs, rv_pkg::sel_rs);
		bad({7'h00, 5'd2, 5'd1, 3'b010, 5'd16, rv_pkg::b_type});
		entry({12'h00c, 5'd5, 3'b000, 5'd1, rv_pkg::i_jal_type}, 32'hc, 5'd1, rv_pkg::alu_add,
			rv_pkg::mem_none, br_jalr, rv_pkg::sel_pc, rv_pkg::sel_const);
		entry({12'h001, 5'd0, 3'b000, 5'd1, rv_pkg::j_type}, 32'h800, 5'd1, rv_pkg::alu_add,
			rv_pkg::mem_none, br_jal, rv_pkg::sel_pc, rv_pkg::sel_const);
		entry({12'hffd, 5'd31, 3'b111, 5'd0, rv_pkg::j_type}, 32'hffff_fffc, 5'd0,
			rv_pkg::alu_add, rv_pkg::mem_none, br_jal, rv_pkg::sel_pc, rv_pkg::sel_const);
		entry({12'h123, 5'd8, 3'b101, 5'd7, rv_pkg::u_ld_type}, 32'h1234_5000, 5'd7,
			rv_pkg::alu_add, rv_pkg::mem_none, br_none, rv_pkg::sel_const, rv_pkg::sel_imm);
		entry({12'hfff, 5'd31, 3'b111, 5'd8, rv_pkg::u_auipc_type}, 32'hffff_f000, 5'd8,
			rv_pkg::alu_add, rv_pkg::mem_none, br_none, rv_pkg::sel_pc, rv_pkg::sel_imm);
		entry({12'h001, 5'd0, 3'b000, 5'd0, rv_pkg::i_break_type}, 32'h0, 5'd0, rv_pkg::alu_add,
			rv_pkg::mem_none, br_none, rv_pkg::sel_const, rv_pkg::sel_const);
		bad(32'h0000_0000);
		bad(32'h0000_000f);
		r_entry(7'h00, 3'b000, 5'd8, 5'd7, 5'd1, rv_pkg::alu_add);
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Back-pressure from the downstream stage, about one stall cycle in four.
	initial begin
		rng = 32'd15942;
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			if (rst_n) begin
				rng = xorshift(rng);
				out_ready <= (rng[1:0] != 2'b00);
			end
		end
	end

	initial begin
		@(posedge rst_n);
		repeat (n_entries * 10 + 100) @(posedge clk);
		fail_run("Timeout: outputs stopped arriving before every legal instruction was issued.");
	end

	always @(posedge clk) begin
		int k;
		if (rst_n) begin
			if (held) begin
				check_value("out_valid (stalled)", 64'(out_valid), 64'd1);
				check_value("pc (stalled)", 64'(pc), 64'(held_pc));
				check_value("imm (stalled)", 64'(imm), 64'(held_imm));
				check_value("controls (stalled)", 64'(ctrl_bus), 64'(held_ctrl));
			end
			held      = out_valid && !out_ready;
			held_pc   = pc;
			held_imm  = imm;
			held_ctrl = ctrl_bus;
			if (out_valid && out_ready) begin
				if (sb.size() == 0) begin
					fail_run("An output was issued with no legal instruction pending.");
				end else begin
					k = sb.pop_front();
					check_value("pc", 64'(pc), 64'(tbl_pc[k]));
					check_value("imm", 64'(imm), 64'(exp_imm[k]));
					check_value("rd", 64'(rd), 64'(exp_rd[k]));
					check_value("rs1", 64'(rs1), 64'(exp_rs1[k]));
					check_value("rs2", 64'(rs2), 64'(exp_rs2[k]));
					check_value("alu_func", 64'(alu_func), 64'(exp_alu[k]));
					check_value("mem_cmd", 64'(mem_cmd), 64'(exp_mem[k]));
					check_value("br_ctrl", 64'(br_ctrl), 64'(exp_br[k]));
					check_value("mux_sel", 64'(mux_sel), 64'(exp_mux[k]));
				end
			end
		end else begin
			held = 1'b0;
		end
	end

	initial begin
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_pc    = 32'h0;
		in_inst  = 32'h0;
		build_table();
		repeat (4) @(posedge clk);
		check_value("out_valid in reset", 64'(out_valid), 64'd0);
		rst_n <= 1'b1;
		@(posedge clk);
		check_value("out_valid after reset", 64'(out_valid), 64'd0);
		check_value("in_ready after reset", 64'(in_ready), 64'd1);
		for (int i = 0; i < n_entries; i++) begin
			in_valid <= 1'b1;
			in_pc    <= tbl_pc[i];
			in_inst  <= tbl_inst[i];
			@(posedge clk);
			while (!in_ready)
				@(posedge clk);
			// Only legal words are expected back, in the order they were accepted.
			if (tbl_legal[i])
				sb.push_back(i);
		end
		in_valid <= 1'b0;
		while (sb.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		if (out_valid) begin
			fail_run("out_valid stayed high after the last expected instruction.");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

//--- decode_top.sv
`timescale 1ns/10ps

module decode_top #(
	parameter int XLEN = rv_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	output logic            in_ready,
	input  logic [XLEN-1:0] in_pc,
	input  logic [31:0]     in_inst,
	output logic            out_valid,
	input  logic            out_ready,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] imm,
	output logic [9:0]      mux_sel,
	output logic [3:0]      br_ctrl,
	output logic [4:0]      alu_func,
	output logic [3:0]      mem_cmd,
	output logic [4:0]      rd
);

	logic            if_id_valid;
	logic            if_id_ready;
	logic [XLEN-1:0] if_id_pc;
	logic [31:0]     if_id_inst;
	logic [4:0]      id_rs1;
	logic [4:0]      id_rs2;
	logic [XLEN-1:0] id_pc;
	logic [XLEN-1:0] id_imm;
	logic [9:0]      id_mux_sel;
	logic [3:0]      id_br_ctrl;
	logic [4:0]      id_alu_func;
	logic [3:0]      id_mem_cmd;
	logic            id_vld;
	logic [4:0]      id_rd;
	logic [4:0]      id_ex_rd;
	logic [4:0]      ex_mem_rd;

	if_id_reg #(.XLEN(XLEN)) u_if_id (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_pc     (in_pc),
		.in_inst   (in_inst),
		.out_valid (if_id_valid),
		.out_ready (if_id_ready),
		.out_pc    (if_id_pc),
		.out_inst  (if_id_inst)
	);

	id_stage #(.XLEN(XLEN)) u_id (
		.if_id_pc    (if_id_pc),
		.if_id_inst  (if_id_inst),
		.if_id_valid (if_id_valid),
		.id_ex_rd    (id_ex_rd),
		.ex_mem_rd   (ex_mem_rd),
		.id_rs1      (id_rs1),
		.id_rs2      (id_rs2),
		.id_pc       (id_pc),
		.id_imm      (id_imm),
		.id_mux_sel  (id_mux_sel),
		.id_br_ctrl  (id_br_ctrl),
		.id_alu_func (id_alu_func),
		.id_mem_cmd  (id_mem_cmd),
		.id_vld      (id_vld),
		.id_rd       (id_rd)
	);

	id_ex_reg #(.XLEN(XLEN)) u_id_ex (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_vld      (id_vld),
		.id_rs1      (id_rs1),
		.id_rs2      (id_rs2),
		.id_pc       (id_pc),
		.id_imm      (id_imm),
		.id_mux_sel  (id_mux_sel),
		.id_br_ctrl  (id_br_ctrl),
		.id_alu_func (id_alu_func),
		.id_mem_cmd  (id_mem_cmd),
		.id_rd       (id_rd),
		.if_id_ready (if_id_ready),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.rs1         (rs1),
		.rs2         (rs2),
		.pc          (pc),
		.imm         (imm),
		.mux_sel     (mux_sel),
		.br_ctrl     (br_ctrl),
		.alu_func    (alu_func),
		.mem_cmd     (mem_cmd),
		.rd          (rd),
		.id_ex_rd    (id_ex_rd),
		.ex_mem_rd   (ex_mem_rd)
	);

endmodule

//--- id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg #(
	parameter int XLEN = rv_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_vld,
	input  logic [4:0]      id_rs1,
	input  logic [4:0]      id_rs2,
	input  logic [XLEN-1:0] id_pc,
	input  logic [XLEN-1:0] id_imm,
	input  logic [9:0]      id_mux_sel,
	input  logic [3:0]      id_br_ctrl,
	input  logic [4:0]      id_alu_func,
	input  logic [3:0]      id_mem_cmd,
	input  logic [4:0]      id_rd,
	output logic            if_id_ready,
	output logic            out_valid,
	input  logic            out_ready,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] imm,
	output logic [9:0]      mux_sel,
	output logic [3:0]      br_ctrl,
	output logic [4:0]      alu_func,
	output logic [3:0]      mem_cmd,
	output logic [4:0]      rd,
	output logic [4:0]      id_ex_rd,
	output logic [4:0]      ex_mem_rd
);

	logic load;

	// Decode is always drained when this stage can move, so illegal words just vanish.
	assign if_id_ready = !out_valid || out_ready;
	assign load        = in_vld && if_id_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			id_ex_rd  <= rv_pkg::zero_reg;
			ex_mem_rd <= rv_pkg::zero_reg;
		end else begin
			if (if_id_ready)
				out_valid <= in_vld;
			if (load) begin
				id_ex_rd  <= id_rd;
				ex_mem_rd <= id_ex_rd;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			rs1      <= id_rs1;
			rs2      <= id_rs2;
			pc       <= id_pc;
			imm      <= id_imm;
			mux_sel  <= id_mux_sel;
			br_ctrl  <= id_br_ctrl;
			alu_func <= id_alu_func;
			mem_cmd  <= id_mem_cmd;
			rd       <= id_rd;
		end
	end

	no_issue_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid);

	hold_bundle: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid
			&& $stable({rs1, rs2, pc, imm, mux_sel, br_ctrl, alu_func, mem_cmd, rd}));

endmodule

//--- id_stage.sv
`timescale 1ns/10ps

module id_stage #(
	parameter int XLEN = rv_pkg::XLEN
) (
	input  logic [XLEN-1:0] if_id_pc,
	input  logic [31:0]     if_id_inst,
	input  logic            if_id_valid,
	input  logic [4:0]      id_ex_rd,
	input  logic [4:0]      ex_mem_rd,
	output logic [4:0]      id_rs1,
	output logic [4:0]      id_rs2,
	output logic [XLEN-1:0] id_pc,
	output logic [XLEN-1:0] id_imm,
	output logic [9:0]      id_mux_sel,
	output logic [3:0]      id_br_ctrl,
	output logic [4:0]      id_alu_func,
	output logic [3:0]      id_mem_cmd,
	output logic            id_vld,
	output logic [4:0]      id_rd
);

	rv_pkg::inst_word_u w;

	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	logic [1:0] opa_sel;
	logic [1:0] opb_sel;
	logic [2:0] fwd_rs1;
	logic [2:0] fwd_rs2;
	logic [2:0] br_low;

	logic signed [31:0] imm_i;
	logic signed [31:0] imm_s;
	logic signed [31:0] imm_b;
	logic signed [31:0] imm_j;
	logic signed [31:0] imm_u;

	// Closest producer wins; x0 is never forwarded.
	function automatic logic [2:0] fwd_sel(input logic [4:0] src, input logic [4:0] ex_rd,
		input logic [4:0] mem_rd);
		if (src == rv_pkg::zero_reg)
			return rv_pkg::f0;
		else if (src == ex_rd)
			return rv_pkg::f1;
		else if (src == mem_rd)
			return rv_pkg::f2;
		else
			return rv_pkg::f0;
	endfunction

	assign w      = if_id_inst;
	assign opcode = w.r.opcode;
	assign funct7 = w.r.funct7;
	assign funct3 = w.r.funct3;

	assign id_rs1 = w.r.rs1;
	assign id_rs2 = w.r.rs2;
	assign id_pc  = if_id_pc;

	assign imm_i = {{20{w.i.imm12[11]}}, w.i.imm12};
	assign imm_s = {{20{w.r.funct7[6]}}, w.r.funct7, w.r.rd};
	assign imm_b = {{20{w.r.funct7[6]}}, w.r.rd[0], w.r.funct7[5:0], w.r.rd[4:1], 1'b0};
	// J-type scatters its bits over the rs1, funct3 and imm12 fields.
	assign imm_j = {{12{w.i.imm12[11]}}, w.i.rs1, w.i.funct3, w.i.imm12[0],
		w.i.imm12[10:1], 1'b0};
	assign imm_u = {w.i.imm12, w.i.rs1, w.i.funct3, 12'b0};

	assign id_mux_sel = {opa_sel, opb_sel, fwd_rs1, fwd_rs2};
	assign id_br_ctrl = {opcode == rv_pkg::i_jal_type, br_low};

	always_comb begin
		id_vld     = if_id_valid;
		id_imm     = '0;
		id_rd      = w.r.rd;
		id_mem_cmd = rv_pkg::mem_none;
		opa_sel    = rv_pkg::sel_rs;
		opb_sel    = rv_pkg::sel_imm;
		br_low     = rv_pkg::dont_branch;

		case (opcode)
			rv_pkg::r_type: begin
				opb_sel = rv_pkg::sel_rs;
			end
			rv_pkg::i_arith_type: begin
				id_imm = XLEN'(imm_i);
			end
			rv_pkg::i_ld_type: begin
				id_imm     = XLEN'(imm_i);
				id_mem_cmd = {1'b0, funct3};
			end
			rv_pkg::i_jal_type: begin
				id_imm  = XLEN'(imm_i);
				opa_sel = rv_pkg::sel_pc;
				opb_sel = rv_pkg::sel_const;
				br_low  = rv_pkg::unc_branch;
			end
			rv_pkg::s_type: begin
				id_imm     = XLEN'(imm_s);
				id_rd      = rv_pkg::zero_reg;
				id_mem_cmd = {1'b1, funct3};
			end
			rv_pkg::b_type: begin
				id_imm  = XLEN'(imm_b);
				id_rd   = rv_pkg::zero_reg;
				opb_sel = rv_pkg::sel_rs;
				br_low  = funct3;
			end
			rv_pkg::j_type: begin
				id_imm  = XLEN'(imm_j);
				opa_sel = rv_pkg::sel_pc;
				opb_sel = rv_pkg::sel_const;
				br_low  = rv_pkg::unc_branch;
			end
			rv_pkg::u_ld_type: begin
				id_imm  = XLEN'(imm_u);
				opa_sel = rv_pkg::sel_const;
			end
			rv_pkg::u_auipc_type: begin
				id_imm  = XLEN'(imm_u);
				opa_sel = rv_pkg::sel_pc;
			end
			rv_pkg::i_break_type: begin
				id_rd   = rv_pkg::zero_reg;
				opa_sel = rv_pkg::sel_const;
				opb_sel = rv_pkg::sel_const;
			end
			default: begin
				id_vld  = 1'b0;
				id_rd   = rv_pkg::zero_reg;
				opa_sel = rv_pkg::sel_const;
				opb_sel = rv_pkg::sel_const;
			end
		endcase

		id_alu_func = rv_pkg::alu_add;
		case (opcode)
			rv_pkg::r_type: begin
				case ({funct7, funct3})
					{rv_pkg::f7_base, rv_pkg::f3_add}:    id_alu_func = rv_pkg::alu_add;
					{rv_pkg::f7_alt, rv_pkg::f3_add}:     id_alu_func = rv_pkg::alu_sub;
					{rv_pkg::f7_base, rv_pkg::f3_xor}:    id_alu_func = rv_pkg::alu_xor;
					{rv_pkg::f7_base, rv_pkg::f3_or}:     id_alu_func = rv_pkg::alu_or;
					{rv_pkg::f7_base, rv_pkg::f3_and}:    id_alu_func = rv_pkg::alu_and;
					{rv_pkg::f7_base, rv_pkg::f3_sll}:    id_alu_func = rv_pkg::alu_sll;
					{rv_pkg::f7_base, rv_pkg::f3_srl}:    id_alu_func = rv_pkg::alu_srl;
					{rv_pkg::f7_alt, rv_pkg::f3_srl}:     id_alu_func = rv_pkg::alu_sra;
					{rv_pkg::f7_base, rv_pkg::f3_slt}:    id_alu_func = rv_pkg::alu_slt;
					{rv_pkg::f7_base, rv_pkg::f3_sltu}:   id_alu_func = rv_pkg::alu_sltu;
					{rv_pkg::f7_mext, rv_pkg::f3_mul}:    id_alu_func = rv_pkg::alu_mul;
					{rv_pkg::f7_mext, rv_pkg::f3_mulh}:   id_alu_func = rv_pkg::alu_mulh;
					{rv_pkg::f7_mext, rv_pkg::f3_mulhsu}: id_alu_func = rv_pkg::alu_mulhsu;
					{rv_pkg::f7_mext, rv_pkg::f3_mulhu}:  id_alu_func = rv_pkg::alu_mulhu;
					default:                              id_vld = 1'b0;
				endcase
			end
			rv_pkg::i_arith_type: begin
				// Shift immediates carry funct7 in the upper imm12 bits.
				case (funct3)
					rv_pkg::f3_add:  id_alu_func = rv_pkg::alu_add;
					rv_pkg::f3_xor:  id_alu_func = rv_pkg::alu_xor;
					rv_pkg::f3_or:   id_alu_func = rv_pkg::alu_or;
					rv_pkg::f3_and:  id_alu_func = rv_pkg::alu_and;
					rv_pkg::f3_slt:  id_alu_func = rv_pkg::alu_slt;
					rv_pkg::f3_sltu: id_alu_func = rv_pkg::alu_sltu;
					rv_pkg::f3_sll: begin
						if (funct7 == rv_pkg::f7_base)
							id_alu_func = rv_pkg::alu_sll;
						else
							id_vld = 1'b0;
					end
					default: begin
						if (funct7 == rv_pkg::f7_base)
							id_alu_func = rv_pkg::alu_srl;
						else if (funct7 == rv_pkg::f7_alt)
							id_alu_func = rv_pkg::alu_sra;
						else
							id_vld = 1'b0;
					end
				endcase
			end
			rv_pkg::b_type: begin
				case (funct3)
					rv_pkg::f3_beq, rv_pkg::f3_bne:   id_alu_func = rv_pkg::alu_xor;
					rv_pkg::f3_blt, rv_pkg::f3_bge:   id_alu_func = rv_pkg::alu_slt;
					rv_pkg::f3_bltu, rv_pkg::f3_bgeu: id_alu_func = rv_pkg::alu_sltu;
					default:                          id_vld = 1'b0;
				endcase
			end
			default: begin
				id_alu_func = rv_pkg::alu_add;
			end
		endcase

		fwd_rs1 = fwd_sel(id_rs1, id_ex_rd, ex_mem_rd);
		fwd_rs2 = fwd_sel(id_rs2, id_ex_rd, ex_mem_rd);

		// Only loads and stores may reach the memory port.
		if (id_vld && opcode != rv_pkg::i_ld_type && opcode != rv_pkg::s_type)
			mem_quiet: assert (id_mem_cmd == rv_pkg::mem_none);
	end

endmodule

//--- if_id_reg.sv
`timescale 1ns/10ps

module if_id_reg #(
	parameter int XLEN = rv_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	output logic            in_ready,
	input  logic [XLEN-1:0] in_pc,
	input  logic [31:0]     in_inst,
	output logic            out_valid,
	input  logic            out_ready,
	output logic [XLEN-1:0] out_pc,
	output logic [31:0]     out_inst
);

	// The slot takes a new word when it is empty or is being drained this cycle.
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_pc   <= in_pc;
			out_inst <= in_inst;
		end
	end

	// A stalled instruction must reach the decoder unchanged.
	hold_inst: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_inst) && $stable(out_pc));

endmodule

//--- project.f
rv_pkg.sv
if_id_reg.sv
id_stage.sv
id_ex_reg.sv
decode_top.sv
decode_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module decode_tb -o decode_sim
./obj_dir/decode_sim | tee sim.log

grep -qxF '** PASS **' sim.log
echo "Simulation passed."

//--- rv_pkg.sv
package rv_pkg;

	localparam int XLEN = 32;

	// Major opcodes of the RV32IM base and M extension.
	localparam logic [6:0] r_type       = 7'b0110011;
	localparam logic [6:0] i_arith_type = 7'b0010011;
	localparam logic [6:0] i_ld_type    = 7'b0000011;
	localparam logic [6:0] i_jal_type   = 7'b1100111;
	localparam logic [6:0] s_type       = 7'b0100011;
	localparam logic [6:0] b_type       = 7'b1100011;
	localparam logic [6:0] j_type       = 7'b1101111;
	localparam logic [6:0] u_ld_type    = 7'b0110111;
	localparam logic [6:0] u_auipc_type = 7'b0010111;
	localparam logic [6:0] i_break_type = 7'b1110011;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;
	localparam logic [6:0] f7_mext = 7'b0000001;

	// Arithmetic funct3, shared by R-type and I-arith.
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_srl  = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// M extension funct3, valid with f7_mext.
	localparam logic [2:0] f3_mul    = 3'b000;
	localparam logic [2:0] f3_mulh   = 3'b001;
	localparam logic [2:0] f3_mulhsu = 3'b010;
	localparam logic [2:0] f3_mulhu  = 3'b011;

	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	localparam logic [4:0] alu_add    = 5'd0;
	localparam logic [4:0] alu_sub    = 5'd1;
	localparam logic [4:0] alu_xor    = 5'd2;
	localparam logic [4:0] alu_or     = 5'd3;
	localparam logic [4:0] alu_and    = 5'd4;
	localparam logic [4:0] alu_sll    = 5'd5;
	localparam logic [4:0] alu_srl    = 5'd6;
	localparam logic [4:0] alu_sra    = 5'd7;
	localparam logic [4:0] alu_slt    = 5'd8;
	localparam logic [4:0] alu_sltu   = 5'd9;
	localparam logic [4:0] alu_mul    = 5'd10;
	localparam logic [4:0] alu_mulh   = 5'd11;
	localparam logic [4:0] alu_mulhsu = 5'd12;
	localparam logic [4:0] alu_mulhu  = 5'd13;

	// Loads are {0, funct3} and stores {1, funct3}.
	localparam logic [3:0] mem_none = 4'b1111;

	// Conditional branches never use these two funct3 values.
	localparam logic [2:0] dont_branch = 3'b010;
	localparam logic [2:0] unc_branch  = 3'b011;

	localparam logic [1:0] sel_rs    = 2'd0;
	localparam logic [1:0] sel_imm   = 2'd1;
	localparam logic [1:0] sel_pc    = 2'd2;
	localparam logic [1:0] sel_const = 2'd3;

	localparam logic [2:0] f0 = 3'd0;
	localparam logic [2:0] f1 = 3'd1;
	localparam logic [2:0] f2 = 3'd2;

	localparam logic [4:0] zero_reg = 5'd0;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} inst_word_u;

endpackage
